//--- all.f
+incdir+hw
hw/n64_ppu_pkg.sv
hw/n64_vinfo_detect.sv
hw/n64_vdemux.sv
hw/color_post.sv
hw/ppu_axil_regs.sv
hw/n64_ppu_top.sv
tests/tb_n64_ppu.sv

//--- hw/color_post.sv
// One registered stage; cfg_i is taken as is, so it must only change between frames
// Gamma is a simple three-way rule rather than a table
`timescale 1ns/10ps
`include "ppu_settings.svh"

module color_post (
  input  logic                    N64_CLK_i,
  input  logic                    arst_n_i,
  input  n64_ppu_pkg::ppu_cfg_t   cfg_i,
  input  logic                    pix_valid_i,
  input  n64_ppu_pkg::n64_pixel_t pix_i,
  output logic                    pix_valid_o,
  output n64_ppu_pkg::ppu_pixel_t pix_o
);

  localparam logic [`PPU_COUT_W-1:0] FULL_SCALE = {`PPU_COUT_W{1'b1}};

  // 16-bit mask, MSB replication, then gamma
  function automatic logic [`PPU_COUT_W-1:0] post_channel(
    input logic [`PPU_CIN_W-1:0] c_in,
    input n64_ppu_pkg::ppu_cfg_t cfg
  );
    logic [`PPU_CIN_W-1:0]  c7;
    logic [`PPU_COUT_W-1:0] c8;
    logic [`PPU_COUT_W-1:0] c_out;
    c7 = c_in;
    if (cfg.mode16) begin
      c7[1:0] = 2'b00;
    end
    c8 = {c7, c7[`PPU_CIN_W-1]};
    case (cfg.gamma)
      2'd1:    c_out = c8 + ((FULL_SCALE - c8) >> 2);  // brighten never exceeds full scale
      2'd2:    c_out = c8 - (c8 >> 2);
      default: c_out = c8;
    endcase
    return c_out;
  endfunction

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= pix_valid_i;
    end
  end

  always_ff @(posedge N64_CLK_i) begin
    if (pix_valid_i) begin
      pix_o.sync <= pix_i.sync;
      pix_o.r    <= post_channel(pix_i.rgb.r, cfg_i);
      pix_o.g    <= post_channel(pix_i.rgb.g, cfg_i);
      pix_o.b    <= post_channel(pix_i.rgb.b, cfg_i);
    end
  end

  // Every input pixel leaves one cycle later with known colour and sync
  a_latency: assert property (@(posedge N64_CLK_i) disable iff (!arst_n_i)
    pix_valid_i |=> pix_valid_o && !$isunknown(pix_o))
    else $error("pixel not delivered one cycle after its input");

endmodule

//--- hw/n64_ppu_pkg.sv
// Packed types shared by the front end and its testbench
// Field order sets the bit layout; sync flags follow the VD[3:0] order
`include "ppu_settings.svh"

package n64_ppu_pkg;

  // Sync nibble, VD bit 3 down to bit 0, all active low
  typedef struct packed {
    logic vsync_n;
    logic clamp_n;
    logic hsync_n;
    logic csync_n;
  } n64_sync_t;

  typedef struct packed {
    logic [`PPU_CIN_W-1:0] r;
    logic [`PPU_CIN_W-1:0] g;
    logic [`PPU_CIN_W-1:0] b;
  } rgb21_t;

  // Pixel as collected from the video bus
  typedef struct packed {
    n64_sync_t sync;
    rgb21_t    rgb;
  } n64_pixel_t;

  // Pixel after colour post-processing
  typedef struct packed {
    n64_sync_t              sync;
    logic [`PPU_COUT_W-1:0] r;
    logic [`PPU_COUT_W-1:0] g;
    logic [`PPU_COUT_W-1:0] b;
  } ppu_pixel_t;

  typedef struct packed {
    logic                   detected;
    logic                   pal;
    logic                   interlaced;
    logic [`PPU_LINE_W-1:0] lines;
  } vinfo_t;

  // Same layout as CONFIG bits 2:0
  // gamma 0 and 3 identity, 1 brighten, 2 darken
  typedef struct packed {
    logic       mode16;
    logic [1:0] gamma;
  } ppu_cfg_t;

  typedef struct packed {
    logic                     awvalid;
    logic [`PPU_AXI_AW-1:0]   awaddr;
    logic                     wvalid;
    logic [`PPU_AXI_DW-1:0]   wdata;
    logic [`PPU_AXI_DW/8-1:0] wstrb;
    logic                     bready;
    logic                     arvalid;
    logic [`PPU_AXI_AW-1:0]   araddr;
    logic                     rready;
  } axil_req_t;

  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [`PPU_AXI_DW-1:0] rdata;
    logic [1:0]             rresp;
  } axil_rsp_t;

endpackage

//--- hw/n64_ppu_top.sv
// N64-side front end in the single N64 clock domain
// Pixels leave 2 cycles after their blue word; no back-pressure on video
`timescale 1ns/10ps
`include "ppu_settings.svh"

module n64_ppu_top (
  input  logic                    N64_CLK_i,
  input  logic                    arst_n_i,
  input  logic                    nvdsync_i,
  input  logic [`PPU_VD_W-1:0]    vd_i,
  input  n64_ppu_pkg::axil_req_t  axil_req_i,
  output n64_ppu_pkg::axil_rsp_t  axil_rsp_o,
  output logic                    pix_valid_o,
  output n64_ppu_pkg::ppu_pixel_t pix_o
);

  n64_ppu_pkg::vinfo_t     vinfo;
  logic                    frame_start;
  n64_ppu_pkg::ppu_cfg_t   cfg;
  logic                    dmx_valid;
  n64_ppu_pkg::n64_pixel_t dmx_pix;

  // ========================================
  // Input side
  // ========================================

  n64_vinfo_detect u_vinfo (
    .N64_CLK_i     (N64_CLK_i),
    .arst_n_i      (arst_n_i),
    .nvdsync_i     (nvdsync_i),
    .vd_sync_i     (n64_ppu_pkg::n64_sync_t'(vd_i[3:0])),
    .vinfo_o       (vinfo),
    .frame_start_o (frame_start)
  );

  n64_vdemux u_vdemux (
    .N64_CLK_i   (N64_CLK_i),
    .arst_n_i    (arst_n_i),
    .nvdsync_i   (nvdsync_i),
    .vd_i        (vd_i),
    .pix_valid_o (dmx_valid),
    .pix_o       (dmx_pix)
  );

  // ========================================
  // Colour path and registers
  // ========================================

  color_post u_color (
    .N64_CLK_i   (N64_CLK_i),
    .arst_n_i    (arst_n_i),
    .cfg_i       (cfg),
    .pix_valid_i (dmx_valid),
    .pix_i       (dmx_pix),
    .pix_valid_o (pix_valid_o),
    .pix_o       (pix_o)
  );

  ppu_axil_regs u_regs (
    .N64_CLK_i     (N64_CLK_i),
    .arst_n_i      (arst_n_i),
    .axil_req_i    (axil_req_i),
    .axil_rsp_o    (axil_rsp_o),
    .vinfo_i       (vinfo),
    .frame_start_i (frame_start),
    .cfg_o         (cfg)
  );

endmodule

//--- hw/n64_vdemux.sv
// Supports only the plain four-word pattern: sync, red, green, blue
// A sync word in mid-pixel drops the partial pixel
`timescale 1ns/10ps
`include "ppu_settings.svh"

module n64_vdemux (
  input  logic                    N64_CLK_i,
  input  logic                    arst_n_i,
  input  logic                    nvdsync_i,
  input  logic [`PPU_VD_W-1:0]    vd_i,
  output logic                    pix_valid_o,
  output n64_ppu_pkg::n64_pixel_t pix_o
);

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_RED,
    PH_GREEN,
    PH_BLUE
  } phase_e;

  phase_e                 phase_q;
  n64_ppu_pkg::n64_sync_t sync_q;
  logic [`PPU_CIN_W-1:0]  red_q;
  logic [`PPU_CIN_W-1:0]  green_q;

  // ========================================
  // Word phase FSM
  // ========================================

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q     <= PH_IDLE;
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= 1'b0;
      if (!nvdsync_i) begin
        phase_q <= PH_RED;
      end else begin
        case (phase_q)
          PH_RED:   phase_q <= PH_GREEN;
          PH_GREEN: phase_q <= PH_BLUE;
          PH_BLUE: begin
            phase_q     <= PH_IDLE;
            pix_valid_o <= 1'b1;
          end
          default:  phase_q <= PH_IDLE;
        endcase
      end
    end
  end

  // ========================================
  // Colour word capture
  // ========================================

  always_ff @(posedge N64_CLK_i) begin
    if (!nvdsync_i) begin
      sync_q <= n64_ppu_pkg::n64_sync_t'(vd_i[3:0]);
    end else begin
      case (phase_q)
        PH_RED:   red_q   <= vd_i[`PPU_CIN_W-1:0];
        PH_GREEN: green_q <= vd_i[`PPU_CIN_W-1:0];
        PH_BLUE: begin
          // Blue goes straight into the output word
          pix_o.sync  <= sync_q;
          pix_o.rgb.r <= red_q;
          pix_o.rgb.g <= green_q;
          pix_o.rgb.b <= vd_i[`PPU_CIN_W-1:0];
        end
        default: ;
      endcase
    end
  end

  // Pixels cannot come closer than one full word pattern
  a_pix_spacing: assert property (@(posedge N64_CLK_i) disable iff (!arst_n_i)
    pix_valid_o |=> !pix_valid_o [*3])
    else $error("pixels closer than 4 cycles");

endmodule

//--- hw/n64_vinfo_detect.sv
// Counts hsync falls per frame from the sync words; the first frame is partial
// Interlace is inferred from alternating line counts only
`timescale 1ns/10ps
`include "ppu_settings.svh"

module n64_vinfo_detect (
  input  logic                   N64_CLK_i,
  input  logic                   arst_n_i,
  input  logic                   nvdsync_i,
  input  n64_ppu_pkg::n64_sync_t vd_sync_i,
  output n64_ppu_pkg::vinfo_t    vinfo_o,
  output logic                   frame_start_o
);

  localparam int IDLE_W = $clog2(`PPU_NOSYNC_TIMEOUT + 1);

  n64_ppu_pkg::n64_sync_t sync_q;
  logic [`PPU_LINE_W-1:0] line_cnt_q;
  logic [IDLE_W-1:0]      idle_cnt_q;
  logic                   prev_ok_q;
  logic                   sync_word;
  logic                   vs_fall;
  logic                   hs_fall;
  logic                   timed_out;

  assign sync_word = ~nvdsync_i;
  assign vs_fall   = sync_word & sync_q.vsync_n & ~vd_sync_i.vsync_n;
  assign hs_fall   = sync_word & sync_q.hsync_n & ~vd_sync_i.hsync_n;
  assign timed_out = (idle_cnt_q == IDLE_W'(`PPU_NOSYNC_TIMEOUT));

  // ========================================
  // Lost input watchdog
  // ========================================

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      idle_cnt_q <= '0;
    end else if (sync_word) begin
      idle_cnt_q <= '0;
    end else if (!timed_out) begin
      idle_cnt_q <= idle_cnt_q + 1'b1;
    end
  end

  // ========================================
  // Line count and frame evaluation
  // ========================================

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q        <= '1;
      line_cnt_q    <= '0;
      prev_ok_q     <= 1'b0;
      vinfo_o       <= '0;
      frame_start_o <= 1'b0;
    end else begin
      frame_start_o <= vs_fall;

      // Forget the last sync state once the input is gone
      if (sync_word) begin
        sync_q <= vd_sync_i;
      end else if (timed_out) begin
        sync_q <= '1;
      end

      if (vs_fall) begin
        vinfo_o.lines      <= line_cnt_q;
        vinfo_o.pal        <= (line_cnt_q > `PPU_PAL_LINES);
        vinfo_o.detected   <= (line_cnt_q >= `PPU_MIN_LINES);
        // Needs a full previous frame to compare against
        vinfo_o.interlaced <= prev_ok_q & (line_cnt_q != vinfo_o.lines);
        prev_ok_q          <= (line_cnt_q >= `PPU_MIN_LINES);
        // Line 0 of the new frame starts here as well
        line_cnt_q         <= hs_fall ? `PPU_LINE_W'(1) : '0;
      end else if (hs_fall) begin
        if (line_cnt_q != '1) begin
          line_cnt_q <= line_cnt_q + 1'b1;
        end
      end else if (timed_out) begin
        vinfo_o.detected <= 1'b0;
        prev_ok_q        <= 1'b0;
        line_cnt_q       <= '0;
      end
    end
  end

endmodule

//--- hw/ppu_axil_regs.sv
// AXI4-Lite slave, one outstanding transfer per direction
// CONFIG reads back at once but reaches the colour path only at the next frame start
`timescale 1ns/10ps
`include "ppu_settings.svh"

module ppu_axil_regs (
  input  logic                   N64_CLK_i,
  input  logic                   arst_n_i,
  input  n64_ppu_pkg::axil_req_t axil_req_i,
  output n64_ppu_pkg::axil_rsp_t axil_rsp_o,
  input  n64_ppu_pkg::vinfo_t    vinfo_i,
  input  logic                   frame_start_i,
  output n64_ppu_pkg::ppu_cfg_t  cfg_o
);

  localparam int CFG_W = $bits(n64_ppu_pkg::ppu_cfg_t);

  n64_ppu_pkg::ppu_cfg_t  cfg_q;
  n64_ppu_pkg::ppu_cfg_t  cfg_active_q;
  logic                   wr_accept;
  logic                   wr_ok;
  logic                   rd_accept;
  logic                   rd_ok;
  logic                   bvalid_q;
  logic [1:0]             bresp_q;
  logic                   rvalid_q;
  logic [1:0]             rresp_q;
  logic [`PPU_AXI_DW-1:0] rdata_n;
  logic [`PPU_AXI_DW-1:0] rdata_q;

  // ========================================
  // Handshake and decode
  // ========================================

  assign wr_accept = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
  assign rd_accept = axil_req_i.arvalid & ~rvalid_q;

  // Only CONFIG is writable, and only through its low byte lane
  assign wr_ok = (axil_req_i.awaddr == `PPU_ADDR_CONFIG) & axil_req_i.wstrb[0];

  always_comb begin
    rdata_n = '0;
    rd_ok   = 1'b1;
    case (axil_req_i.araddr)
      `PPU_ADDR_CONFIG: rdata_n[CFG_W-1:0] = cfg_q;
      `PPU_ADDR_STATUS: begin
        rdata_n[0] = vinfo_i.detected;
        rdata_n[1] = vinfo_i.pal;
        rdata_n[2] = vinfo_i.interlaced;
      end
      `PPU_ADDR_LINES:  rdata_n[`PPU_LINE_W-1:0] = vinfo_i.lines;
      default:          rd_ok = 1'b0;
    endcase
  end

  always_comb begin
    axil_rsp_o.awready = wr_accept;
    axil_rsp_o.wready  = wr_accept;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.bresp   = bresp_q;
    axil_rsp_o.arready = rd_accept;
    axil_rsp_o.rvalid  = rvalid_q;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = rresp_q;
  end

  // ========================================
  // Registers and response state
  // ========================================

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bvalid_q     <= 1'b0;
      rvalid_q     <= 1'b0;
      cfg_q        <= '0;
      cfg_active_q <= '0;
    end else begin
      if (wr_accept) begin
        bvalid_q <= 1'b1;
      end else if (axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end

      if (rd_accept) begin
        rvalid_q <= 1'b1;
      end else if (axil_req_i.rready) begin
        rvalid_q <= 1'b0;
      end

      if (wr_accept && wr_ok) begin
        cfg_q <= n64_ppu_pkg::ppu_cfg_t'(axil_req_i.wdata[CFG_W-1:0]);
      end

      // Shadow copy switches only between frames
      if (frame_start_i) begin
        cfg_active_q <= cfg_q;
      end
    end
  end

  always_ff @(posedge N64_CLK_i) begin
    if (wr_accept) begin
      bresp_q <= wr_ok ? `PPU_RESP_OKAY : `PPU_RESP_SLVERR;
    end
    if (rd_accept) begin
      rdata_q <= rdata_n;
      rresp_q <= rd_ok ? `PPU_RESP_OKAY : `PPU_RESP_SLVERR;
    end
  end

  assign cfg_o = cfg_active_q;

  // Responses stay put until the master takes them
  a_bvalid_hold: assert property (@(posedge N64_CLK_i) disable iff (!arst_n_i)
    bvalid_q && !axil_req_i.bready |=> bvalid_q && $stable(bresp_q))
    else $error("write response changed before bready");

  a_rvalid_hold: assert property (@(posedge N64_CLK_i) disable iff (!arst_n_i)
    rvalid_q && !axil_req_i.rready |=> rvalid_q && $stable(rdata_q) && $stable(rresp_q))
    else $error("read response changed before rready");

endmodule

//--- hw/ppu_settings.svh
// Widths, thresholds and register map of the N64 post-processing front end
// Line thresholds assume whole frames; the colour path assumes 7-bit in, 8-bit out
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// Video bus and colour widths
`define PPU_VD_W            7
`define PPU_CIN_W           7
`define PPU_COUT_W          8

// Line counting
`define PPU_LINE_W          10
`define PPU_PAL_LINES       288
`define PPU_MIN_LINES       200

// Idle cycles on nVDSYNC before the input counts as lost
`define PPU_NOSYNC_TIMEOUT  1024

// AXI4-Lite bus
`define PPU_AXI_AW          8
`define PPU_AXI_DW          32
`define PPU_RESP_OKAY       2'b00
`define PPU_RESP_SLVERR     2'b10

// Register map
`define PPU_ADDR_CONFIG     8'h00
`define PPU_ADDR_STATUS     8'h04
`define PPU_ADDR_LINES      8'h08

`endif

//--- tests/tb_n64_ppu.sv
// Directed tests of the N64 front end with short 8-pixel lines and sync-red-green-blue words
// Every frame start is a vsync falling edge, so each frame loads the config written before it
`timescale 1ns/10ps
`include "ppu_settings.svh"

module tb_n64_ppu;

  localparam int CLK_PERIOD = 4;
  localparam int PIX_PER_LN = 8;
  localparam int WAIT_LIMIT = 64;

  logic                    n64_clk;
  logic                    arst_n;
  logic                    nvdsync;
  logic [`PPU_VD_W-1:0]    vd;
  n64_ppu_pkg::axil_req_t  axil_req;
  n64_ppu_pkg::axil_rsp_t  axil_rsp;
  logic                    pix_valid;
  n64_ppu_pkg::ppu_pixel_t pix;

  logic [15:0]             lfsr_state;
  n64_ppu_pkg::ppu_cfg_t   cfg_written;
  time                     exp_time_q[$];
  n64_ppu_pkg::ppu_pixel_t exp_pix_q[$];
  int                      check_count;
  int                      err_count;
  int                      timeout_count;
  int                      pix_checked;

  n64_ppu_top u_dut (
    .N64_CLK_i   (n64_clk),
    .arst_n_i    (arst_n),
    .nvdsync_i   (nvdsync),
    .vd_i        (vd),
    .axil_req_i  (axil_req),
    .axil_rsp_o  (axil_rsp),
    .pix_valid_o (pix_valid),
    .pix_o       (pix)
  );

  initial begin
    n64_clk = 1'b0;
    forever #(CLK_PERIOD / 2) n64_clk = ~n64_clk;
  end

  // ========================================
  // Helpers
  // ========================================

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [6:0] random7();
    logic [6:0] val;
    logic       fb;
    val = '0;
    for (int i = 0; i < 7; i++) begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      val        = {val[5:0], fb};
    end
    return val;
  endfunction

  // Mask for 16-bit mode, widen with the top bit, then gamma
  function automatic logic [7:0] expect_channel(input logic [6:0] c,
                                                input n64_ppu_pkg::ppu_cfg_t cfg);
    logic [6:0] c7;
    int         v;
    c7 = cfg.mode16 ? (c & 7'h7C) : c;
    v  = c7 * 2 + c7[6];
    if (cfg.gamma == 2'd1) begin
      v = v + (255 - v) / 4;
    end else if (cfg.gamma == 2'd2) begin
      v = v - v / 4;
    end
    return v[7:0];
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("Timed out at %0t waiting for %s", $time, what);
  endtask

  // ========================================
  // AXI4-Lite master
  // ========================================

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    int waited;
    waited = 0;
    @(posedge n64_clk);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= strb;
    axil_req.bready  <= 1'b1;
    @(posedge n64_clk);
    while (!axil_rsp.awready && waited < WAIT_LIMIT) begin
      @(posedge n64_clk);
      waited++;
    end
    if (!axil_rsp.awready) begin
      report_timeout("write acceptance");
    end else begin
      check_value("wready with awready", axil_rsp.wready, 1);
    end
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    waited = 0;
    @(posedge n64_clk);
    while (!axil_rsp.bvalid && waited < WAIT_LIMIT) begin
      @(posedge n64_clk);
      waited++;
    end
    if (!axil_rsp.bvalid) begin
      report_timeout("write response");
    end
    resp = axil_rsp.bresp;
    axil_req.bready <= 1'b0;
    // CONFIG takes the write whenever its low byte lane is enabled
    if (addr == `PPU_ADDR_CONFIG && strb[0]) begin
      cfg_written.mode16 = data[2];
      cfg_written.gamma  = data[1:0];
    end
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int waited;
    waited = 0;
    @(posedge n64_clk);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    axil_req.rready  <= 1'b1;
    @(posedge n64_clk);
    while (!axil_rsp.arready && waited < WAIT_LIMIT) begin
      @(posedge n64_clk);
      waited++;
    end
    if (!axil_rsp.arready) begin
      report_timeout("read acceptance");
    end
    axil_req.arvalid <= 1'b0;
    waited = 0;
    @(posedge n64_clk);
    while (!axil_rsp.rvalid && waited < WAIT_LIMIT) begin
      @(posedge n64_clk);
      waited++;
    end
    if (!axil_rsp.rvalid) begin
      report_timeout("read response");
    end
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    axil_req.rready <= 1'b0;
  endtask

  // ========================================
  // Video generator and scoreboard
  // ========================================

  task automatic send_pixel(input n64_ppu_pkg::n64_sync_t sync,
                            input n64_ppu_pkg::ppu_cfg_t cfg);
    n64_ppu_pkg::ppu_pixel_t exp;
    logic [6:0]              r;
    logic [6:0]              g;
    logic [6:0]              b;
    r        = random7();
    g        = random7();
    b        = random7();
    exp.sync = sync;
    exp.r    = expect_channel(r, cfg);
    exp.g    = expect_channel(g, cfg);
    exp.b    = expect_channel(b, cfg);
    @(posedge n64_clk);
    nvdsync <= 1'b0;
    vd      <= {{(`PPU_VD_W - 4){1'b0}}, sync};
    @(posedge n64_clk);
    nvdsync <= 1'b1;
    vd      <= r;
    @(posedge n64_clk);
    vd <= g;
    @(posedge n64_clk);
    vd <= b;
    // Blue is sampled on the next edge
    exp_time_q.push_back($time + CLK_PERIOD);
    exp_pix_q.push_back(exp);
  endtask

  task automatic send_frame(input int lines);
    n64_ppu_pkg::ppu_cfg_t  cfg;
    n64_ppu_pkg::n64_sync_t sync;
    cfg = cfg_written;
    for (int ln = 0; ln < lines; ln++) begin
      for (int px = 0; px < PIX_PER_LN; px++) begin
        sync.vsync_n = (ln != 0);
        sync.clamp_n = 1'b1;
        sync.hsync_n = (px != 0);
        sync.csync_n = sync.vsync_n & sync.hsync_n;
        send_pixel(sync, cfg);
      end
    end
  endtask

  task automatic wait_pixels_drained();
    int waited;
    waited = 0;
    while (exp_pix_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(posedge n64_clk);
      waited++;
    end
    if (exp_pix_q.size() != 0) begin
      report_timeout("outstanding pixels");
      exp_pix_q.delete();
      exp_time_q.delete();
    end
  endtask

  always @(posedge n64_clk) begin : pixel_monitor
    time                     exp_t;
    n64_ppu_pkg::ppu_pixel_t exp_p;
    if (arst_n && pix_valid) begin
      if (exp_pix_q.size() == 0) begin
        err_count++;
        $display("Pixel appeared at %0t with no pixel sent", $time);
      end else begin
        exp_t = exp_time_q.pop_front();
        exp_p = exp_pix_q.pop_front();
        pix_checked++;
        check_value("pixel latency", $time - exp_t, 2 * CLK_PERIOD);
        check_value("pixel", pix, exp_p);
      end
    end
  end

  // ========================================
  // Directed tests
  // ========================================

  task automatic test_reset_state();
    logic [31:0] data;
    logic [1:0]  resp;
    check_value("pix_valid_o after reset", pix_valid, 0);
    check_value("awready after reset", axil_rsp.awready, 0);
    check_value("wready after reset", axil_rsp.wready, 0);
    check_value("bvalid after reset", axil_rsp.bvalid, 0);
    check_value("arready after reset", axil_rsp.arready, 0);
    check_value("rvalid after reset", axil_rsp.rvalid, 0);
    axi_read(`PPU_ADDR_STATUS, data, resp);
    check_value("STATUS after reset", data, 0);
    check_value("STATUS read resp", resp, `PPU_RESP_OKAY);
    axi_read(`PPU_ADDR_LINES, data, resp);
    check_value("LINES after reset", data, 0);
  endtask

  task automatic test_register_access();
    logic [31:0] data;
    logic [1:0]  resp;
    axi_write(`PPU_ADDR_CONFIG, 32'h5, 4'hF, resp);
    check_value("CONFIG write resp", resp, `PPU_RESP_OKAY);
    axi_read(`PPU_ADDR_CONFIG, data, resp);
    check_value("CONFIG readback", data, 32'h5);
    check_value("CONFIG read resp", resp, `PPU_RESP_OKAY);
    axi_write(`PPU_ADDR_STATUS, 32'h7, 4'hF, resp);
    check_value("STATUS write resp", resp, `PPU_RESP_SLVERR);
    axi_write(`PPU_ADDR_CONFIG, 32'h2, 4'hE, resp);
    check_value("CONFIG write without lane 0 resp", resp, `PPU_RESP_SLVERR);
    axi_read(8'h0C, data, resp);
    check_value("unmapped read resp", resp, `PPU_RESP_SLVERR);
    axi_read(`PPU_ADDR_CONFIG, data, resp);
    check_value("CONFIG after rejected writes", data, 32'h5);
    axi_write(`PPU_ADDR_CONFIG, 32'h0, 4'hF, resp);
    check_value("CONFIG clear resp", resp, `PPU_RESP_OKAY);
  endtask

  task automatic test_ntsc_detect();
    logic [31:0] data;
    logic [1:0]  resp;
    send_frame(263);
    send_frame(263);
    wait_pixels_drained();
    axi_read(`PPU_ADDR_STATUS, data, resp);
    check_value("STATUS for NTSC", data, 32'h1);
    axi_read(`PPU_ADDR_LINES, data, resp);
    check_value("LINES for NTSC", data, 263);
    // Detection drops after the idle limit
    repeat (`PPU_NOSYNC_TIMEOUT + 8) @(posedge n64_clk);
    axi_read(`PPU_ADDR_STATUS, data, resp);
    check_value("detected after idle", data[0], 0);
  endtask

  task automatic test_pal_interlace();
    logic [31:0] data;
    logic [1:0]  resp;
    send_frame(312);
    send_frame(313);
    send_frame(312);
    send_frame(313);
    wait_pixels_drained();
    axi_read(`PPU_ADDR_STATUS, data, resp);
    check_value("STATUS for PAL interlaced", data, 32'h7);
    // Last completed frame is the third one
    axi_read(`PPU_ADDR_LINES, data, resp);
    check_value("LINES for PAL", data, 312);
  endtask

  task automatic test_pixel_path();
    logic [1:0] resp;
    int         start;
    axi_write(`PPU_ADDR_CONFIG, 32'h0, 4'h1, resp);
    start = pix_checked;
    send_frame(4);
    send_frame(4);
    wait_pixels_drained();
    check_value("pixels seen", pix_checked - start, 8 * PIX_PER_LN);
  endtask

  task automatic test_frame_sync_config();
    logic [1:0] resp;
    fork
      send_frame(6);
      begin
        repeat (40) @(posedge n64_clk);
        axi_write(`PPU_ADDR_CONFIG, 32'h5, 4'h1, resp);
      end
    join
    check_value("brighten write resp", resp, `PPU_RESP_OKAY);
    send_frame(6);
    fork
      send_frame(6);
      begin
        repeat (40) @(posedge n64_clk);
        axi_write(`PPU_ADDR_CONFIG, 32'h2, 4'h1, resp);
      end
    join
    check_value("darken write resp", resp, `PPU_RESP_OKAY);
    send_frame(6);
    wait_pixels_drained();
  endtask

  initial begin
    lfsr_state    = 16'd46076;
    cfg_written   = '0;
    check_count   = 0;
    err_count     = 0;
    timeout_count = 0;
    pix_checked   = 0;
    nvdsync       = 1'b1;
    vd            = '0;
    axil_req      = '0;
    arst_n        = 1'b0;
    repeat (8) @(posedge n64_clk);
    arst_n <= 1'b1;
    @(posedge n64_clk);
    test_reset_state();
    test_register_access();
    test_ntsc_detect();
    test_pal_interlace();
    test_pixel_path();
    test_frame_sync_config();
    wait_pixels_drained();
    $display("Summary: %0d checks, %0d pixels, %0d errors, %0d timeouts",
             check_count, pix_checked, err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
